/* common/xfer_config.svh */
`ifndef XFER_CONFIG_SVH
`define XFER_CONFIG_SVH

// fifo address width, 2**AW entries
`define XFER_FIFO_AW 2

// register bank geometry
`define XFER_ADDR_W 4
`define XFER_DATA_W 32

// opcode + address + data
`define XFER_REC_W 38

// saturating drop counter
`define XFER_DROP_W 8

`endif

/* common/xfer_pkg.sv */
// shared types for the register bridge
package xfer_pkg;

	// register command opcode, top two bits of a record
	typedef enum logic [1:0] {
		CMD_NOP   = 2'd0, // no bank action, no response
		CMD_WRITE = 2'd1, // write data to addressed register
		CMD_READ  = 2'd2, // read addressed register, one response
		CMD_CLEAR = 2'd3  // zero every register at once
	} cmd_op_e;

	// wclk side packer states
	typedef enum logic {
		PK_IDLE = 1'b0, // ready for a new command
		PK_HOLD = 1'b1  // record parked until fifo has room
	} pack_state_e;

	// record layout, msb first
	//   opcode  [37:36]
	//   address [35:32]
	//   data    [31:0]
	// bit positions follow the widths in xfer_config.svh
	// the packer builds the record with a plain concatenation
	// the drain splits it back with the same offsets
	// nop records still travel through the fifo
	// and are dropped only at decode

endpackage

/* async_fifo/async_fifo.sv */
`timescale 1ns/1ps

module async_fifo #(
	parameter int WA = 2,  // address bits, depth is 2**WA
	parameter int WD = 38  // data bits
) (
	output logic [WD-1:0] rdat,   // read data, valid cycle after ren
	output logic          rempty, // registered empty, rclk
	output logic          wfull,  // registered full, wclk

	input  logic [WD-1:0] wdat,   // write data
	input  logic          wen,    // write strobe
	input  logic          ren,    // read strobe

	input  logic          wclk,   // write side clock
	input  logic          rclk,   // read side clock
	input  logic          rstn    // async reset, both sides
);

	logic [WA:0] wadr;        // binary write address, extra wrap bit
	logic [WA:0] wptr;        // gray write pointer
	logic [WA:0] radr;        // binary read address, extra wrap bit
	logic [WA:0] rptr;        // gray read pointer
	logic [WA:0] rptr_s0;     // rptr sync, first stage
	logic [WA:0] rptr_s1;     // rptr sync, second stage
	logic [WA:0] wptr_s0;     // wptr sync, first stage
	logic [WA:0] wptr_s1;     // wptr sync, second stage
	logic [WA:0] wadr_nxt;
	logic [WA:0] wptr_nxt;
	logic [WA:0] radr_nxt;
	logic [WA:0] rptr_nxt;
	logic [WA:0] full_cmp;    // synced rptr with top two bits flipped

	logic [WD-1:0] ram [0:2**WA-1];

	// dual port storage
	always_ff @(posedge wclk) begin
		if (wen)
			ram[wadr[WA-1:0]] <= wdat; // writes on every wen
	end

	always_ff @(posedge rclk) begin
		if (ren)
			rdat <= ram[radr[WA-1:0]]; // registered read port
	end

	// write side pointers
	assign wadr_nxt = wadr + {{WA{1'b0}}, (wen & ~wfull)}; // binary step
	assign wptr_nxt = wadr_nxt ^ (wadr_nxt >> 1);           // to gray

	always_ff @(posedge wclk, negedge rstn) begin
		if (!rstn) begin
			wadr <= '0;
			wptr <= '0;
		end else begin
			wadr <= wadr_nxt;
			wptr <= wptr_nxt;
		end
	end

	// read pointer into wclk
	always_ff @(posedge wclk, negedge rstn) begin
		if (!rstn) begin
			rptr_s0 <= '0;
			rptr_s1 <= '0;
		end else begin
			rptr_s0 <= rptr;    // metastable stage
			rptr_s1 <= rptr_s0; // settled
		end
	end

	// full when write gray equals read gray with top two bits inverted
	assign full_cmp = {~rptr_s1[WA:WA-1], rptr_s1[WA-2:0]};

	always_ff @(posedge wclk, negedge rstn) begin
		if (!rstn)
			wfull <= 1'b0;
		else
			wfull <= (wptr_nxt == full_cmp); // predicted from next ptr
	end

	// read side pointers
	assign radr_nxt = radr + {{WA{1'b0}}, (ren & ~rempty)}; // binary step
	assign rptr_nxt = radr_nxt ^ (radr_nxt >> 1);            // to gray

	always_ff @(posedge rclk, negedge rstn) begin
		if (!rstn) begin
			radr <= '0;
			rptr <= '0;
		end else begin
			radr <= radr_nxt;
			rptr <= rptr_nxt;
		end
	end

	// write pointer into rclk
	always_ff @(posedge rclk, negedge rstn) begin
		if (!rstn) begin
			wptr_s0 <= '0;
			wptr_s1 <= '0;
		end else begin
			wptr_s0 <= wptr;    // metastable stage
			wptr_s1 <= wptr_s0; // settled
		end
	end

	// empty when next read gray catches synced write gray
	always_ff @(posedge rclk, negedge rstn) begin
		if (!rstn)
			rempty <= 1'b1;
		else
			rempty <= (rptr_nxt == wptr_s1);
	end

endmodule

/* logic/cmd_packer.sv */
`timescale 1ns/1ps
`include "xfer_config.svh"

module cmd_packer (
	input  logic                    wclk,
	input  logic                    rstn,
	input  logic                    cmd_strobe, // one cycle command pulse
	input  xfer_pkg::cmd_op_e       cmd_op,
	input  logic [`XFER_ADDR_W-1:0] cmd_addr,
	input  logic [`XFER_DATA_W-1:0] cmd_data,
	input  logic                    wfull,      // fifo full, registered
	output logic                    wen,        // fifo write, registered
	output logic [`XFER_REC_W-1:0]  wdat,       // packed record
	output logic                    busy,       // record parked
	output logic [`XFER_DROP_W-1:0] drop_count  // strobes lost while busy
);

	xfer_pkg::pack_state_e state;
	logic [`XFER_REC_W-1:0] rec;    // incoming command as a record
	logic                   accept; // strobe taken in idle
	logic                   drop;   // strobe lost in hold

	assign rec    = {cmd_op, cmd_addr, cmd_data}; // opcode in top bits
	assign accept = cmd_strobe && (state == xfer_pkg::PK_IDLE);
	assign drop   = cmd_strobe && (state == xfer_pkg::PK_HOLD);
	assign busy   = (state == xfer_pkg::PK_HOLD);

	// wfull only reflects a write one cycle later, so a strobe
	// right behind a write is parked until the flag is current
	always_ff @(posedge wclk, negedge rstn) begin
		if (!rstn) begin
			state <= xfer_pkg::PK_IDLE;
			wen   <= 1'b0;
		end else begin
			wen <= 1'b0; // single cycle write
			case (state)
				xfer_pkg::PK_IDLE: begin
					if (cmd_strobe) begin
						if (wfull || wen)
							state <= xfer_pkg::PK_HOLD; // no room known yet
						else
							wen <= 1'b1;                // straight through
					end
				end
				xfer_pkg::PK_HOLD: begin
					if (!wfull) begin
						wen   <= 1'b1;              // flush parked record
						state <= xfer_pkg::PK_IDLE;
					end
				end
				default: state <= xfer_pkg::PK_IDLE;
			endcase
		end
	end

	// record register, held through PK_HOLD
	always_ff @(posedge wclk) begin
		if (accept)
			wdat <= rec;
	end

	// saturating drop counter
	always_ff @(posedge wclk, negedge rstn) begin
		if (!rstn)
			drop_count <= '0;
		else if (drop && (drop_count != {`XFER_DROP_W{1'b1}}))
			drop_count <= drop_count + 1'b1;
	end

endmodule

/* logic/cmd_drain.sv */
`timescale 1ns/1ps
`include "xfer_config.svh"

module cmd_drain (
	input  logic                    rclk,
	input  logic                    rstn,
	input  logic                    rempty,     // fifo empty, registered
	input  logic [`XFER_REC_W-1:0]  rdat,       // fifo data, cycle after ren
	input  logic [`XFER_DATA_W-1:0] bank_rdata, // bank data, cycle after re
	output logic                    ren,        // fifo pop
	output logic                    bank_we,
	output logic                    bank_re,
	output logic                    bank_clr,
	output logic [`XFER_ADDR_W-1:0] bank_addr,
	output logic [`XFER_DATA_W-1:0] bank_wdata,
	output logic                    rsp_strobe, // one pulse per read
	output logic [`XFER_DATA_W-1:0] rsp_data
);

	xfer_pkg::cmd_op_e rec_op; // opcode field of current record
	logic              fetch_vld; // rdat holds a fresh record
	logic              rd_pend;   // bank_rdata valid this cycle

	// pop as long as anything is queued, rclk never stalls
	assign ren = ~rempty;

	// record fields
	assign rec_op     = xfer_pkg::cmd_op_e'(rdat[`XFER_REC_W-1:`XFER_ADDR_W+`XFER_DATA_W]);
	assign bank_addr  = rdat[`XFER_ADDR_W+`XFER_DATA_W-1:`XFER_DATA_W];
	assign bank_wdata = rdat[`XFER_DATA_W-1:0];

	// fetch valid tracks the ren to rdat delay
	always_ff @(posedge rclk, negedge rstn) begin
		if (!rstn)
			fetch_vld <= 1'b0;
		else
			fetch_vld <= ren;
	end

	// opcode decode, acts on the bank in the rdat cycle
	always_comb begin
		bank_we  = 1'b0;
		bank_re  = 1'b0;
		bank_clr = 1'b0;
		if (fetch_vld) begin
			case (rec_op)
				xfer_pkg::CMD_WRITE: bank_we  = 1'b1;
				xfer_pkg::CMD_READ:  bank_re  = 1'b1;
				xfer_pkg::CMD_CLEAR: bank_clr = 1'b1;
				default:             bank_we  = 1'b0; // nop, nothing to do
			endcase
		end
	end

	// read pending lines up bank data with the response
	always_ff @(posedge rclk, negedge rstn) begin
		if (!rstn) begin
			rd_pend    <= 1'b0;
			rsp_strobe <= 1'b0;
		end else begin
			rd_pend    <= bank_re;
			rsp_strobe <= rd_pend; // three cycles after ren
		end
	end

	always_ff @(posedge rclk) begin
		if (rd_pend)
			rsp_data <= bank_rdata; // captured with the strobe
	end

endmodule

/* logic/reg_bank.sv */
`timescale 1ns/1ps
`include "xfer_config.svh"

module reg_bank (
	input  logic                    rclk,
	input  logic                    rstn,
	input  logic                    we,    // write strobe
	input  logic                    re,    // read strobe
	input  logic                    clr,   // clear all registers
	input  logic [`XFER_ADDR_W-1:0] addr,  // shared read/write address
	input  logic [`XFER_DATA_W-1:0] wdata,
	output logic [`XFER_DATA_W-1:0] rdata  // registered, holds between reads
);

	logic [`XFER_DATA_W-1:0] regs [0:2**`XFER_ADDR_W-1];

	// register file, clr wins over we
	always_ff @(posedge rclk, negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < 2**`XFER_ADDR_W; i++)
				regs[i] <= '0;
		end else if (clr) begin
			for (int i = 0; i < 2**`XFER_ADDR_W; i++)
				regs[i] <= '0; // whole bank in one cycle
		end else if (we) begin
			regs[addr] <= wdata;
		end
	end

	// read port, one cycle latency
	always_ff @(posedge rclk, negedge rstn) begin
		if (!rstn)
			rdata <= '0;
		else if (re)
			rdata <= regs[addr];
	end

endmodule

/* logic/cdc_regbridge.sv */
`timescale 1ns/1ps
`include "xfer_config.svh"

module cdc_regbridge (
	input  logic                    wclk,       // master clock
	input  logic                    rclk,       // bank clock
	input  logic                    rstn,
	input  logic                    cmd_strobe,
	input  xfer_pkg::cmd_op_e       cmd_op,
	input  logic [`XFER_ADDR_W-1:0] cmd_addr,
	input  logic [`XFER_DATA_W-1:0] cmd_data,
	output logic                    busy,
	output logic [`XFER_DROP_W-1:0] drop_count,
	output logic                    rsp_strobe,
	output logic [`XFER_DATA_W-1:0] rsp_data
);

	logic                    wen;    // packer to fifo, wclk
	logic [`XFER_REC_W-1:0]  wdat;
	logic                    wfull;
	logic                    ren;    // drain to fifo, rclk
	logic [`XFER_REC_W-1:0]  rdat;
	logic                    rempty;
	logic                    bank_we;
	logic                    bank_re;
	logic                    bank_clr;
	logic [`XFER_ADDR_W-1:0] bank_addr;
	logic [`XFER_DATA_W-1:0] bank_wdata;
	logic [`XFER_DATA_W-1:0] bank_rdata;

	cmd_packer u_packer (
		.wclk(wclk), .rstn(rstn),
		.cmd_strobe(cmd_strobe), .cmd_op(cmd_op),
		.cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.wfull(wfull), .wen(wen), .wdat(wdat),
		.busy(busy), .drop_count(drop_count)
	);

	async_fifo #(.WA(`XFER_FIFO_AW), .WD(`XFER_REC_W)) u_fifo (
		.rdat(rdat), .rempty(rempty), .wfull(wfull),
		.wdat(wdat), .wen(wen), .ren(ren),
		.wclk(wclk), .rclk(rclk), .rstn(rstn)
	);

	cmd_drain u_drain (
		.rclk(rclk), .rstn(rstn),
		.rempty(rempty), .rdat(rdat), .bank_rdata(bank_rdata),
		.ren(ren), .bank_we(bank_we), .bank_re(bank_re), .bank_clr(bank_clr),
		.bank_addr(bank_addr), .bank_wdata(bank_wdata),
		.rsp_strobe(rsp_strobe), .rsp_data(rsp_data)
	);

	reg_bank u_bank (
		.rclk(rclk), .rstn(rstn),
		.we(bank_we), .re(bank_re), .clr(bank_clr),
		.addr(bank_addr), .wdata(bank_wdata), .rdata(bank_rdata)
	);

endmodule

/* verification/regbridge_checker.sv */
`timescale 1ns/1ps
`include "xfer_config.svh"

module regbridge_checker (
	input  logic                    wclk,
	input  logic                    rclk,
	input  logic                    rstn,
	input  logic                    cmd_strobe,
	input  xfer_pkg::cmd_op_e       cmd_op,
	input  logic [`XFER_ADDR_W-1:0] cmd_addr,
	input  logic [`XFER_DATA_W-1:0] cmd_data,
	input  logic                    busy,
	input  logic [`XFER_DROP_W-1:0] drop_count,
	input  logic                    rsp_strobe,
	input  logic [`XFER_DATA_W-1:0] rsp_data,
	output int                      pending     // reads not yet answered
);

	logic [`XFER_DATA_W-1:0] model [0:2**`XFER_ADDR_W-1]; // bank as the master sees it
	logic [`XFER_DATA_W-1:0] exp_q [$];                  // read values in command order
	logic [`XFER_DATA_W-1:0] exp_val;
	int                      err_cnt;
	int                      exp_drops;      // strobes seen while busy
	int                      reads_accepted;
	int                      rsp_cnt;

	initial begin
		for (int i = 0; i < 2**`XFER_ADDR_W; i++)
			model[i] = '0; // bank resets to zero
		err_cnt        = 0;
		exp_drops      = 0;
		reads_accepted = 0;
		rsp_cnt        = 0;
		pending        = 0;
	end

	// commands in wclk order, busy decides accept or drop
	always @(posedge wclk) begin
		if (rstn && cmd_strobe) begin
			if (busy)
				exp_drops++; // model left alone
			else begin
				case (cmd_op)
					xfer_pkg::CMD_WRITE: model[cmd_addr] = cmd_data;
					xfer_pkg::CMD_READ: begin
						exp_q.push_back(model[cmd_addr]);
						reads_accepted++;
					end
					xfer_pkg::CMD_CLEAR: begin
						for (int i = 0; i < 2**`XFER_ADDR_W; i++)
							model[i] = '0;
					end
					default: ; // nop
				endcase
			end
			pending = exp_q.size();
		end
	end

	// responses come back on rclk
	always @(posedge rclk) begin
		if (rstn && rsp_strobe) begin
			rsp_cnt++;
			if (exp_q.size() == 0) begin
				$display("response strobe with no read outstanding, data %h", rsp_data);
				err_cnt++;
			end else begin
				exp_val = exp_q.pop_front();
				if (rsp_data !== exp_val) begin
					$display("mismatch rsp_data: got %h, expected %h", rsp_data, exp_val);
					err_cnt++;
				end
			end
			pending = exp_q.size();
		end
	end

	task automatic run_final_checks(output int errs, output int rsps, output int drops);
		logic [`XFER_DROP_W-1:0] exp_sat;
		exp_sat = (exp_drops > 2**`XFER_DROP_W - 1) ? '1 : exp_drops[`XFER_DROP_W-1:0];
		if (drop_count !== exp_sat) begin
			$display("mismatch drop_count: got %h, expected %h", drop_count, exp_sat);
			err_cnt++;
		end
		if (exp_drops == 0) begin
			$display("no command was dropped, so the drop path went untested");
			err_cnt++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected read responses were never seen", exp_q.size());
			err_cnt++;
		end
		if (rsp_cnt != reads_accepted) begin
			$display("got %0d responses for %0d accepted reads", rsp_cnt, reads_accepted);
			err_cnt++;
		end
		errs  = err_cnt;
		rsps  = rsp_cnt;
		drops = exp_drops;
	endtask

endmodule

/* verification/tb_cdc_regbridge.sv */
`timescale 1ns/1ps
`include "xfer_config.svh"

module tb_cdc_regbridge;

	localparam int MAX_ROWS   = 64;  // command table capacity
	localparam int WAIT_LIMIT = 400; // cycles allowed per wait loop

	logic                    wclk;
	logic                    rclk;
	logic                    rstn;
	logic                    cmd_strobe;
	xfer_pkg::cmd_op_e       cmd_op;
	logic [`XFER_ADDR_W-1:0] cmd_addr;
	logic [`XFER_DATA_W-1:0] cmd_data;
	logic                    busy;
	logic [`XFER_DROP_W-1:0] drop_count;
	logic                    rsp_strobe;
	logic [`XFER_DATA_W-1:0] rsp_data;
	int                      pending; // reads still owed a response

	// command table, one row per strobe
	xfer_pkg::cmd_op_e       tbl_op     [MAX_ROWS];
	logic [`XFER_ADDR_W-1:0] tbl_addr   [MAX_ROWS];
	logic [`XFER_DATA_W-1:0] tbl_data   [MAX_ROWS];
	bit                      tbl_ignore [MAX_ROWS]; // strobe even while busy
	int                      n_rows;
	int                      tb_errors;   // timeouts
	logic [31:0]             lcg_state;
	int                      chk_errors;
	int                      chk_rsps;
	int                      chk_drops;

	cdc_regbridge DUT (
		.wclk(wclk), .rclk(rclk), .rstn(rstn),
		.cmd_strobe(cmd_strobe), .cmd_op(cmd_op),
		.cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.busy(busy), .drop_count(drop_count),
		.rsp_strobe(rsp_strobe), .rsp_data(rsp_data)
	);

	regbridge_checker chk (
		.wclk(wclk), .rclk(rclk), .rstn(rstn),
		.cmd_strobe(cmd_strobe), .cmd_op(cmd_op),
		.cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.busy(busy), .drop_count(drop_count),
		.rsp_strobe(rsp_strobe), .rsp_data(rsp_data),
		.pending(pending)
	);

	initial begin
		rclk = 1'b0;
		forever #4 rclk = ~rclk; // 8 ns bank clock
	end

	initial begin
		wclk = 1'b0;
		forever #6.5 wclk = ~wclk; // 13 ns, drifts against rclk
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345; // classic lcg constants
	endfunction

	task automatic add_row(input xfer_pkg::cmd_op_e op, input logic [`XFER_ADDR_W-1:0] addr,
			input logic [`XFER_DATA_W-1:0] data, input bit ign);
		if (n_rows < MAX_ROWS) begin
			tbl_op[n_rows]     = op;
			tbl_addr[n_rows]   = addr;
			tbl_data[n_rows]   = data;
			tbl_ignore[n_rows] = ign;
			n_rows++;
		end
	endtask

	task automatic build_table();
		add_row(xfer_pkg::CMD_READ, 4'd0, 32'h0, 1'b0);  // untouched after reset
		add_row(xfer_pkg::CMD_READ, 4'd5, 32'h0, 1'b0);
		add_row(xfer_pkg::CMD_READ, 4'd15, 32'h0, 1'b0);
		add_row(xfer_pkg::CMD_WRITE, 4'd3, 32'ha5a5_0003, 1'b0);
		add_row(xfer_pkg::CMD_READ, 4'd3, 32'h0, 1'b0);  // written value back
		add_row(xfer_pkg::CMD_READ, 4'd4, 32'h0, 1'b0);  // neighbour unaffected
		add_row(xfer_pkg::CMD_WRITE, 4'd4, 32'h1234_5678, 1'b0);
		add_row(xfer_pkg::CMD_READ, 4'd4, 32'h0, 1'b0);
		add_row(xfer_pkg::CMD_READ, 4'd3, 32'h0, 1'b0);
		add_row(xfer_pkg::CMD_NOP, 4'd3, 32'hdead_beef, 1'b0); // must not write
		add_row(xfer_pkg::CMD_READ, 4'd3, 32'h0, 1'b0);  // still the old value
		add_row(xfer_pkg::CMD_CLEAR, 4'd0, 32'h0, 1'b0);
		add_row(xfer_pkg::CMD_READ, 4'd3, 32'h0, 1'b0);
		add_row(xfer_pkg::CMD_READ, 4'd4, 32'h0, 1'b0);
		add_row(xfer_pkg::CMD_NOP, 4'd9, 32'hffff_ffff, 1'b0);
		add_row(xfer_pkg::CMD_READ, 4'd9, 32'h0, 1'b0);
		// burst, well over the fifo depth
		for (int i = 0; i < 10; i++) begin
			lcg_state = lcg_next(lcg_state);
			add_row(xfer_pkg::CMD_WRITE, i[`XFER_ADDR_W-1:0], lcg_state, 1'b0);
		end
		for (int i = 0; i < 10; i++)
			add_row(xfer_pkg::CMD_READ, i[`XFER_ADDR_W-1:0], 32'h0, 1'b0);
		// back to back strobes ignoring busy, some get dropped
		for (int i = 7; i < 12; i++) begin
			lcg_state = lcg_next(lcg_state);
			add_row(xfer_pkg::CMD_WRITE, i[`XFER_ADDR_W-1:0], lcg_state, 1'b1);
		end
		for (int i = 7; i < 12; i++)
			add_row(xfer_pkg::CMD_READ, i[`XFER_ADDR_W-1:0], 32'h0, 1'b0);
		add_row(xfer_pkg::CMD_READ, 4'd0, 32'h0, 1'b0); // last one drains all
	endtask

	// called 1 ns after a wclk edge
	task automatic wait_until_idle();
		int cycles;
		cycles = 0;
		while (busy && cycles < WAIT_LIMIT) begin
			@(posedge wclk);
			#1;
			cycles++;
		end
		if (busy) begin
			$display("timeout: busy stayed high for %0d wclk cycles", WAIT_LIMIT);
			tb_errors++;
		end
	endtask

	task automatic apply_row(input int i);
		if (!tbl_ignore[i])
			wait_until_idle(); // master respects busy
		cmd_strobe = 1'b1;
		cmd_op     = tbl_op[i];
		cmd_addr   = tbl_addr[i];
		cmd_data   = tbl_data[i];
		@(posedge wclk);
		#1;
		cmd_strobe = 1'b0; // next row may raise it again right away
	endtask

	task automatic wait_for_responses();
		int cycles;
		cycles = 0;
		while (pending != 0 && cycles < WAIT_LIMIT) begin
			@(posedge rclk);
			#1;
			cycles++;
		end
		if (pending != 0) begin
			$display("timeout: %0d read responses never arrived", pending);
			tb_errors++;
		end
	endtask

	initial begin
		rstn       = 1'b0;
		cmd_strobe = 1'b0;
		cmd_op     = xfer_pkg::CMD_NOP;
		cmd_addr   = '0;
		cmd_data   = '0;
		tb_errors  = 0;
		n_rows     = 0;
		lcg_state  = 32'd7; // fixed seed
		build_table();
		repeat (8) @(posedge rclk);
		rstn = 1'b1;
		@(posedge wclk);
		#1;
		for (int i = 0; i < n_rows; i++)
			apply_row(i);
		wait_for_responses();
		chk.run_final_checks(chk_errors, chk_rsps, chk_drops);
		$display("errors %0d (checker %0d, timeouts %0d), responses %0d, drops %0d",
			chk_errors + tb_errors, chk_errors, tb_errors, chk_rsps, chk_drops);
		if (chk_errors + tb_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* flist.f */
+incdir+common
common/xfer_pkg.sv
async_fifo/async_fifo.sv
logic/cmd_packer.sv
logic/cmd_drain.sv
logic/reg_bank.sv
logic/cdc_regbridge.sv
verification/regbridge_checker.sv
verification/tb_cdc_regbridge.sv

/* Bender.yml */
package:
  name: cdc_regbridge

sources:
  - include_dirs:
      - common
    files:
      - common/xfer_pkg.sv
      - async_fifo/async_fifo.sv
      - logic/cmd_packer.sv
      - logic/cmd_drain.sv
      - logic/reg_bank.sv
      - logic/cdc_regbridge.sv

  - target: test
    include_dirs:
      - common
    files:
      - verification/regbridge_checker.sv
      - verification/tb_cdc_regbridge.sv
